// ==== hdl/tlp_pkg.sv ====
package tlp_pkg;

    // ------------------------------------------------------------
    // widths
    // ------------------------------------------------------------
    localparam int DW_PER_BEAT = 4;

    typedef logic [31:0]            dw_t;
    typedef logic [DW_PER_BEAT-1:0] keep_dw_t;
    typedef logic [6:0]             fmt_type_t;
    // wide enough for the default four channels
    typedef logic [1:0]             chan_t;

    // ------------------------------------------------------------
    // fmt/type codes, bits 31:25 of the first header dword
    // ------------------------------------------------------------
    // completion without data, 3 dw header
    localparam fmt_type_t FT_CPL   = 7'b0000101;
    // completion with data
    localparam fmt_type_t FT_CPLD  = 7'b0100101;
    // config read, type 0 and type 1 share the upper bits
    localparam fmt_type_t FT_CFGRD = 7'b0000010;
    localparam fmt_type_t FT_CFGWR = 7'b0100010;

    // ------------------------------------------------------------
    // beat and word layouts
    // ------------------------------------------------------------
    // dword lane n sits at data[n], lane 0 holds the first header dword
    typedef struct packed {
        dw_t [DW_PER_BEAT-1:0] data;
        keep_dw_t              keep_dw;
        logic                  first;
        logic                  last;
    } tlp_beat_t;

    typedef struct packed {
        dw_t   data;
        logic  last;
        chan_t chan;
    } host_word_t;

    // host receive side, one flag bit per lane
    typedef struct packed {
        dw_t [DW_PER_BEAT-1:0] data;
        keep_dw_t              valid;
        keep_dw_t              first;
        keep_dw_t              last;
    } rx_lanes_t;

endpackage

// ==== hdl/tlp_rx_filter.sv ====
`timescale 1ns/10ps

module tlp_rx_filter import tlp_pkg::*; (
    input  logic      clk_pcie,
    input  logic      rst,
    input  tlp_beat_t i_rx_beat,
    input  logic      i_rx_valid,
    input  logic      i_cfg_filter,
    input  logic      i_all_filter,
    output rx_lanes_t o_rx_lanes
);

    fmt_type_t fmt_type;
    logic      is_cpl;
    logic      is_cfg;
    logic      drop_new;
    logic      drop_now;
    logic      drop_q;
    logic      pkt_open_q;

    // ------------------------------------------------------------
    // classify on the header beat
    // ------------------------------------------------------------
    assign fmt_type = i_rx_beat.data[0][31:25];
    assign is_cpl   = (fmt_type == FT_CPL) || (fmt_type == FT_CPLD);
    assign is_cfg   = (fmt_type == FT_CFGRD) || (fmt_type == FT_CFGWR);

    assign drop_new = (i_cfg_filter && is_cfg) ||
                      (i_all_filter && !is_cpl && !is_cfg);

    // decision made on first, carried over the remaining beats
    assign drop_now = i_rx_beat.first ? drop_new : drop_q;

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            drop_q     <= 1'b0;
            pkt_open_q <= 1'b0;
        end else if (i_rx_valid) begin
            drop_q     <= drop_now;
            pkt_open_q <= !i_rx_beat.last;
        end
    end

    // ------------------------------------------------------------
    // register surviving beats into the host lane layout
    // ------------------------------------------------------------
    always_ff @(posedge clk_pcie) begin
        o_rx_lanes.data  <= i_rx_beat.data;
        // only lane 0 can carry the header
        o_rx_lanes.first <= keep_dw_t'(i_rx_beat.first);
        for (int n = 0; n < DW_PER_BEAT; n++) begin
            // last lane is the top one of a contiguous keep mask
            o_rx_lanes.last[n] <= i_rx_beat.last &&
                (i_rx_beat.keep_dw == keep_dw_t'((1 << (n + 1)) - 1));
        end
        if (rst) begin
            o_rx_lanes.valid <= '0;
        end else if (i_rx_valid && !drop_now) begin
            o_rx_lanes.valid <= i_rx_beat.keep_dw;
        end else begin
            o_rx_lanes.valid <= '0;
        end
    end

    // core must open every packet with a header beat
    a_first_opens_pkt: assert property (
        @(posedge clk_pcie) disable iff (rst)
        (i_rx_valid && !pkt_open_q) |-> i_rx_beat.first
    );

endmodule

// ==== hdl/tlp_tx_packer.sv ====
`timescale 1ns/10ps

module tlp_tx_packer import tlp_pkg::*; (
    input  logic       clk_pcie,
    input  logic       rst,
    input  host_word_t i_host_word,
    input  logic       i_host_valid,
    output tlp_beat_t  o_beat,
    output logic       o_beat_valid,
    output chan_t      o_chan
);

    dw_t [DW_PER_BEAT-1:0] data_q;
    dw_t [DW_PER_BEAT-1:0] beat_data;
    keep_dw_t              fill_q;
    keep_dw_t              lane_sel;
    keep_dw_t              fill_next;
    logic                  pkt_open_q;
    logic                  head_word;
    logic                  emit;
    chan_t                 chan_q;
    chan_t                 cur_chan;

    // ------------------------------------------------------------
    // lane steering
    // ------------------------------------------------------------
    // fill_q is a thermometer mask, so the next free lane is one-hot
    assign lane_sel  = {fill_q[DW_PER_BEAT-2:0], 1'b1} & ~fill_q;
    assign fill_next = fill_q | lane_sel;
    assign emit      = fill_next[DW_PER_BEAT-1] || i_host_word.last;

    // packet header word, nothing of this packet seen yet
    assign head_word = !pkt_open_q && (fill_q == '0);
    assign cur_chan  = head_word ? i_host_word.chan : chan_q;

    always_comb begin
        for (int n = 0; n < DW_PER_BEAT; n++) begin
            if (lane_sel[n]) begin
                beat_data[n] = i_host_word.data;
            end else if (fill_q[n]) begin
                beat_data[n] = data_q[n];
            end else begin
                // unused lanes go out as zero
                beat_data[n] = '0;
            end
        end
    end

    // ------------------------------------------------------------
    // beat assembly
    // ------------------------------------------------------------
    always_ff @(posedge clk_pcie) begin
        if (i_host_valid) begin
            data_q <= beat_data;
            chan_q <= cur_chan;
        end
        if (i_host_valid && emit) begin
            o_beat.data    <= beat_data;
            o_beat.keep_dw <= fill_next;
            // pkt_open_q is set only once a beat of the packet went out
            o_beat.first   <= !pkt_open_q;
            o_beat.last    <= i_host_word.last;
            o_chan         <= cur_chan;
        end
        if (rst) begin
            fill_q       <= '0;
            pkt_open_q   <= 1'b0;
            o_beat_valid <= 1'b0;
        end else begin
            o_beat_valid <= i_host_valid && emit;
            if (i_host_valid) begin
                fill_q <= emit ? keep_dw_t'(0) : fill_next;
                if (emit) begin
                    pkt_open_q <= !i_host_word.last;
                end
            end
        end
    end

endmodule

// ==== hdl/tlp_pkt_queue.sv ====
`timescale 1ns/10ps

module tlp_pkt_queue import tlp_pkg::*; #(
    parameter int QUEUE_DEPTH = 16
) (
    input  logic      clk_pcie,
    input  logic      rst,
    input  tlp_beat_t i_wr_beat,
    input  logic      i_wr_en,
    input  logic      i_pop,
    output tlp_beat_t o_head,
    output logic      o_head_valid,
    output logic      o_has_pkt
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    typedef logic [PTR_W-1:0] ptr_t;
    typedef logic [CNT_W-1:0] cnt_t;

    tlp_beat_t mem [QUEUE_DEPTH];
    ptr_t      wr_ptr_q;
    ptr_t      rd_ptr_q;
    cnt_t      beat_cnt_q;
    cnt_t      pkt_cnt_q;
    logic      pkt_in;
    logic      pkt_out;

    // wrap explicitly, depth need not be a power of two
    function automatic ptr_t ptr_inc(input ptr_t p);
        if (p == ptr_t'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr_t'(p + 1'b1);
    endfunction

    // ------------------------------------------------------------
    // beat storage
    // ------------------------------------------------------------
    always_ff @(posedge clk_pcie) begin
        if (i_wr_en) begin
            mem[wr_ptr_q] <= i_wr_beat;
        end
    end

    // head read straight out of the array
    assign o_head       = mem[rd_ptr_q];
    assign o_head_valid = (beat_cnt_q != '0);

    // ------------------------------------------------------------
    // pointers and counts
    // ------------------------------------------------------------
    assign pkt_in    = i_wr_en && i_wr_beat.last;
    assign pkt_out   = i_pop && o_head.last;
    assign o_has_pkt = (pkt_cnt_q != '0);

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            beat_cnt_q <= '0;
            pkt_cnt_q  <= '0;
        end else begin
            if (i_wr_en) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (i_pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            beat_cnt_q <= beat_cnt_q + cnt_t'(i_wr_en) - cnt_t'(i_pop);
            pkt_cnt_q  <= pkt_cnt_q + cnt_t'(pkt_in) - cnt_t'(pkt_out);
        end
    end

    // host side keeps each channel within one queue depth
    a_no_write_full: assert property (
        @(posedge clk_pcie) disable iff (rst)
        i_wr_en |-> (beat_cnt_q != cnt_t'(QUEUE_DEPTH))
    );

    a_no_pop_empty: assert property (
        @(posedge clk_pcie) disable iff (rst)
        i_pop |-> o_head_valid
    );

endmodule

// ==== hdl/tlp_tx_arbiter.sv ====
`timescale 1ns/10ps

module tlp_tx_arbiter import tlp_pkg::*; #(
    parameter int NUM_CHANNELS = 4
) (
    input  logic                         clk_pcie,
    input  logic                         rst,
    input  tlp_beat_t [NUM_CHANNELS-1:0] i_heads,
    input  logic [NUM_CHANNELS-1:0]      i_head_valid,
    input  logic [NUM_CHANNELS-1:0]      i_has_pkt,
    output logic [NUM_CHANNELS-1:0]      o_pop,
    output tlp_beat_t                    o_tx_beat,
    output logic                         o_tx_valid,
    input  logic                         i_tx_ready
);

    typedef enum logic {
        IDLE,
        SEND
    } arb_state_t;

    arb_state_t state_q;
    chan_t      sel_q;
    chan_t      pick;
    logic       any_pkt;
    logic       tx_fire;

    // ------------------------------------------------------------
    // fixed priority toward the lowest channel
    // ------------------------------------------------------------
    always_comb begin
        pick    = '0;
        any_pkt = 1'b0;
        for (int i = NUM_CHANNELS - 1; i >= 0; i--) begin
            if (i_has_pkt[i]) begin
                pick    = chan_t'(i);
                any_pkt = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // output mux and pop
    // ------------------------------------------------------------
    assign o_tx_beat  = i_heads[sel_q];
    assign o_tx_valid = (state_q == SEND) && i_head_valid[sel_q];
    assign tx_fire    = o_tx_valid && i_tx_ready;

    always_comb begin
        o_pop        = '0;
        o_pop[sel_q] = tx_fire;
    end

    // selection held until the last beat is taken
    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            state_q <= IDLE;
            sel_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (i_tx_ready && any_pkt) begin
                        state_q <= SEND;
                        sel_q   <= pick;
                    end
                end
                SEND: begin
                    if (tx_fire && o_tx_beat.last) begin
                        state_q <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // a pop only hits the queue that still counts the packet in flight
    a_pop_onehot: assert property (
        @(posedge clk_pcie) disable iff (rst)
        $onehot0(o_pop) && ((o_pop & ~i_has_pkt) == '0)
    );

    // a stalled beat stays put until the core takes it
    a_hold_on_stall: assert property (
        @(posedge clk_pcie) disable iff (rst)
        (o_tx_valid && !i_tx_ready) |=> (o_tx_valid && $stable(o_tx_beat))
    );

endmodule

// ==== hdl/tlp_ctrl_top.sv ====
`timescale 1ns/10ps

module tlp_ctrl_top import tlp_pkg::*; #(
    parameter int NUM_CHANNELS = 4,
    parameter int QUEUE_DEPTH  = 16
) (
    input  logic       clk_pcie,
    input  logic       rst,
    // receive path from the core
    input  tlp_beat_t  i_rx_beat,
    input  logic       i_rx_valid,
    input  logic       i_cfg_filter,
    input  logic       i_all_filter,
    output rx_lanes_t  o_rx_lanes,
    // transmit path from the host
    input  host_word_t i_host_word,
    input  logic       i_host_valid,
    output tlp_beat_t  o_tx_beat,
    output logic       o_tx_valid,
    input  logic       i_tx_ready
);

    tlp_beat_t                    pk_beat;
    logic                         pk_valid;
    chan_t                        pk_chan;
    tlp_beat_t [NUM_CHANNELS-1:0] q_head;
    logic [NUM_CHANNELS-1:0]      q_head_valid;
    logic [NUM_CHANNELS-1:0]      q_has_pkt;
    logic [NUM_CHANNELS-1:0]      q_pop;
    logic [NUM_CHANNELS-1:0]      q_wr_en;

    if (NUM_CHANNELS > (1 << $bits(chan_t))) begin : g_chan_check
        $error("NUM_CHANNELS does not fit in chan_t");
    end

    // ------------------------------------------------------------
    // receive
    // ------------------------------------------------------------
    tlp_rx_filter i_tlp_rx_filter (
        .clk_pcie     ( clk_pcie     ),
        .rst          ( rst          ),
        .i_rx_beat    ( i_rx_beat    ),
        .i_rx_valid   ( i_rx_valid   ),
        .i_cfg_filter ( i_cfg_filter ),
        .i_all_filter ( i_all_filter ),
        .o_rx_lanes   ( o_rx_lanes   )
    );

    // ------------------------------------------------------------
    // transmit
    // ------------------------------------------------------------
    tlp_tx_packer i_tlp_tx_packer (
        .clk_pcie     ( clk_pcie     ),
        .rst          ( rst          ),
        .i_host_word  ( i_host_word  ),
        .i_host_valid ( i_host_valid ),
        .o_beat       ( pk_beat      ),
        .o_beat_valid ( pk_valid     ),
        .o_chan       ( pk_chan      )
    );

    for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_queue
        // channel decode into per-queue write enables
        assign q_wr_en[c] = pk_valid && (pk_chan == chan_t'(c));

        tlp_pkt_queue #(
            .QUEUE_DEPTH ( QUEUE_DEPTH )
        ) i_tlp_pkt_queue (
            .clk_pcie     ( clk_pcie        ),
            .rst          ( rst             ),
            .i_wr_beat    ( pk_beat         ),
            .i_wr_en      ( q_wr_en[c]      ),
            .i_pop        ( q_pop[c]        ),
            .o_head       ( q_head[c]       ),
            .o_head_valid ( q_head_valid[c] ),
            .o_has_pkt    ( q_has_pkt[c]    )
        );
    end

    tlp_tx_arbiter #(
        .NUM_CHANNELS ( NUM_CHANNELS )
    ) i_tlp_tx_arbiter (
        .clk_pcie     ( clk_pcie     ),
        .rst          ( rst          ),
        .i_heads      ( q_head       ),
        .i_head_valid ( q_head_valid ),
        .i_has_pkt    ( q_has_pkt    ),
        .o_pop        ( q_pop        ),
        .o_tx_beat    ( o_tx_beat    ),
        .o_tx_valid   ( o_tx_valid   ),
        .i_tx_ready   ( i_tx_ready   )
    );

endmodule

// ==== verif/tlp_tb_model.svh ====
`ifndef TLP_TB_MODEL_SVH
`define TLP_TB_MODEL_SVH

// ------------------------------------------------------------
// random source, 16-bit galois lfsr
// ------------------------------------------------------------
logic [15:0] lfsr_state = 16'd72;

function automatic logic lfsr_bit();
    logic out_bit;
    out_bit = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out_bit) begin
        lfsr_state = lfsr_state ^ 16'hB400;
    end
    return out_bit;
endfunction

// one lfsr step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_bit()};
    end
    return v;
endfunction

// ------------------------------------------------------------
// receive filter reference
// ------------------------------------------------------------
function automatic logic rx_passes(input fmt_type_t ft, input logic cfg_f, input logic all_f);
    logic cpl_pkt;
    logic cfg_pkt;
    cpl_pkt = (ft == FT_CPL) || (ft == FT_CPLD);
    cfg_pkt = (ft == FT_CFGRD) || (ft == FT_CFGWR);
    if (cfg_f && cfg_pkt) begin
        return 1'b0;
    end
    if (all_f && !cpl_pkt && !cfg_pkt) begin
        return 1'b0;
    end
    return 1'b1;
endfunction

// low n lanes set
function automatic keep_dw_t low_mask(input int lanes);
    return keep_dw_t'((1 << lanes) - 1);
endfunction

function automatic rx_lanes_t rx_expect(input tlp_beat_t b);
    rx_lanes_t e;
    e.data     = b.data;
    e.valid    = b.keep_dw;
    e.first    = '0;
    e.first[0] = b.first;
    e.last     = '0;
    for (int n = 0; n < DW_PER_BEAT; n++) begin
        if (b.last && (b.keep_dw == low_mask(n + 1))) begin
            e.last[n] = 1'b1;
        end
    end
    return e;
endfunction

// ------------------------------------------------------------
// expected transmit beats, one list per channel
// ------------------------------------------------------------
tlp_beat_t exp_beats [NUM_CH][Q_DEPTH];
int        exp_wr    [NUM_CH];
int        exp_rd    [NUM_CH];
dw_t       pkt_words [12];

task automatic clear_expected();
    for (int c = 0; c < NUM_CH; c++) begin
        exp_wr[c] = 0;
        exp_rd[c] = 0;
    end
endtask

// four host words per beat, a short beat at the end of the packet
task automatic model_pack(input int ch, input int len);
    tlp_beat_t b;
    int        lane;
    b       = '0;
    b.first = 1'b1;
    lane    = 0;
    for (int w = 0; w < len; w++) begin
        b.data[lane]    = pkt_words[w];
        b.keep_dw[lane] = 1'b1;
        lane++;
        if ((lane == DW_PER_BEAT) || (w == len - 1)) begin
            b.last = (w == len - 1);
            exp_beats[ch][exp_wr[ch]] = b;
            exp_wr[ch]++;
            b    = '0;
            lane = 0;
        end
    end
endtask

// lowest channel with beats still owed
function automatic int next_channel();
    for (int c = 0; c < NUM_CH; c++) begin
        if (exp_rd[c] < exp_wr[c]) begin
            return c;
        end
    end
    return -1;
endfunction

// ------------------------------------------------------------
// error counters
// ------------------------------------------------------------
int mismatch_count = 0;
int other_errors   = 0;

task automatic flag_mismatch(input string msg);
    mismatch_count++;
    $display("MISMATCH at %0t: %s", $time, msg);
endtask

task automatic flag_failure(input string msg);
    other_errors++;
    $display("ERROR at %0t: %s", $time, msg);
endtask

`endif

// ==== verif/tb_tlp_ctrl.sv ====
`timescale 1ns/10ps

module tb_tlp_ctrl import tlp_pkg::*; ();

    localparam int NUM_CH      = 4;
    localparam int Q_DEPTH     = 16;
    localparam int RX_PKTS     = 24;
    localparam int TX_PKTS     = 14;
    localparam int TX_ROUNDS   = 3;
    localparam int HOLD_CYCLES = 20;
    localparam int DRAIN_LIMIT = 2000;

    logic       clk_pcie = 1'b0;
    logic       rst;
    tlp_beat_t  rx_beat;
    logic       rx_valid;
    logic       cfg_filter;
    logic       all_filter;
    rx_lanes_t  rx_lanes;
    host_word_t host_word;
    logic       host_valid;
    tlp_beat_t  tx_beat;
    logic       tx_valid;
    logic       tx_ready;

    // lanes expected one cycle after the beat was driven
    rx_lanes_t  rx_exp;
    logic       rx_exp_live;

    `include "tlp_tb_model.svh"

    always #20 clk_pcie = ~clk_pcie;

    tlp_ctrl_top #(
        .NUM_CHANNELS ( NUM_CH  ),
        .QUEUE_DEPTH  ( Q_DEPTH )
    ) i_tlp_ctrl_top (
        .clk_pcie     ( clk_pcie   ),
        .rst          ( rst        ),
        .i_rx_beat    ( rx_beat    ),
        .i_rx_valid   ( rx_valid   ),
        .i_cfg_filter ( cfg_filter ),
        .i_all_filter ( all_filter ),
        .o_rx_lanes   ( rx_lanes   ),
        .i_host_word  ( host_word  ),
        .i_host_valid ( host_valid ),
        .o_tx_beat    ( tx_beat    ),
        .o_tx_valid   ( tx_valid   ),
        .i_tx_ready   ( tx_ready   )
    );

    // ------------------------------------------------------------
    // receive path
    // ------------------------------------------------------------
    task automatic check_rx_lanes();
        if (!rx_exp_live) begin
            if (rx_lanes.valid != '0) begin
                flag_mismatch($sformatf("lane valid %b, expected none", rx_lanes.valid));
            end
        end else begin
            if (rx_lanes.valid != rx_exp.valid) begin
                flag_mismatch($sformatf("lane valid %b, expected %b",
                                        rx_lanes.valid, rx_exp.valid));
            end
            if (rx_lanes.first != rx_exp.first) begin
                flag_mismatch($sformatf("lane first %b, expected %b",
                                        rx_lanes.first, rx_exp.first));
            end
            if (rx_lanes.last != rx_exp.last) begin
                flag_mismatch($sformatf("lane last %b, expected %b",
                                        rx_lanes.last, rx_exp.last));
            end
            for (int n = 0; n < DW_PER_BEAT; n++) begin
                if (rx_exp.valid[n] && (rx_lanes.data[n] != rx_exp.data[n])) begin
                    flag_mismatch($sformatf("lane %0d data %h, expected %h",
                                            n, rx_lanes.data[n], rx_exp.data[n]));
                end
            end
        end
    endtask

    // check the previous beat, then drive the next one
    task automatic rx_cycle(input tlp_beat_t b, input logic v, input logic pass);
        @(negedge clk_pcie);
        check_rx_lanes();
        rx_beat     = b;
        rx_valid    = v;
        rx_exp      = rx_expect(b);
        rx_exp_live = v && pass;
    endtask

    task automatic send_rx_packet();
        tlp_beat_t b;
        fmt_type_t ft;
        int        nbeats;
        logic      pass;
        nbeats = 1 + (rand_bits(2) % 3);
        case (rand_bits(3))
            0: ft = FT_CPL;
            1: ft = FT_CPLD;
            2: ft = FT_CFGRD;
            3: ft = FT_CFGWR;
            default: ft = fmt_type_t'(rand_bits(7));
        endcase
        // decided on the header and kept for the whole packet
        pass = rx_passes(ft, cfg_filter, all_filter);
        for (int i = 0; i < nbeats; i++) begin
            for (int n = 0; n < DW_PER_BEAT; n++) begin
                b.data[n] = rand_bits(32);
            end
            b.first = (i == 0);
            b.last  = (i == nbeats - 1);
            if (i == 0) begin
                b.data[0][31:25] = ft;
            end
            b.keep_dw = b.last ? low_mask(1 + rand_bits(2)) : keep_dw_t'('1);
            rx_cycle(b, 1'b1, pass);
            if (rand_bits(2) == 0) begin
                rx_cycle(b, 1'b0, 1'b0);
            end
        end
    endtask

    task automatic rx_burst(input logic cfg_f, input logic all_f);
        cfg_filter = cfg_f;
        all_filter = all_f;
        for (int p = 0; p < RX_PKTS; p++) begin
            send_rx_packet();
        end
        // flush so the last beat is checked before filters change
        rx_cycle(rx_beat, 1'b0, 1'b0);
    endtask

    // ------------------------------------------------------------
    // transmit path
    // ------------------------------------------------------------
    task automatic send_host_packet(input int ch, input int len);
        for (int w = 0; w < len; w++) begin
            @(negedge clk_pcie);
            host_valid     = 1'b1;
            host_word.data = pkt_words[w];
            host_word.last = (w == len - 1);
            // only the header word sets the channel and later words carry noise
            host_word.chan = (w == 0) ? chan_t'(ch) : chan_t'(rand_bits(2));
            if (rand_bits(2) == 0) begin
                @(negedge clk_pcie);
                host_valid     = 1'b0;
                host_word.data = rand_bits(32);
            end
        end
        @(negedge clk_pcie);
        host_valid = 1'b0;
    endtask

    task automatic check_tx_beat(input int ch);
        tlp_beat_t e;
        e = exp_beats[ch][exp_rd[ch]];
        exp_rd[ch]++;
        if (tx_beat.keep_dw != e.keep_dw) begin
            flag_mismatch($sformatf("ch %0d keep_dw %b, expected %b",
                                    ch, tx_beat.keep_dw, e.keep_dw));
        end
        if ((tx_beat.first != e.first) || (tx_beat.last != e.last)) begin
            flag_mismatch($sformatf("ch %0d first/last %b%b, expected %b%b",
                                    ch, tx_beat.first, tx_beat.last, e.first, e.last));
        end
        for (int n = 0; n < DW_PER_BEAT; n++) begin
            if (e.keep_dw[n] && (tx_beat.data[n] != e.data[n])) begin
                flag_mismatch($sformatf("ch %0d lane %0d data %h, expected %h",
                                        ch, n, tx_beat.data[n], e.data[n]));
            end
        end
    endtask

    task automatic drain_tx(input int total);
        tlp_beat_t held_beat;
        logic      held;
        logic      in_pkt;
        int        got;
        int        cycles;
        int        stall;
        int        cur_ch;
        held   = 1'b0;
        in_pkt = 1'b0;
        got    = 0;
        cycles = 0;
        stall  = 0;
        cur_ch = 0;
        while ((got < total) && (cycles < DRAIN_LIMIT)) begin
            @(negedge clk_pcie);
            cycles++;
            if (held && (!tx_valid || (tx_beat !== held_beat))) begin
                flag_mismatch("o_tx_beat changed while the core stalled");
            end
            // random stalls of up to four cycles
            if (stall > 0) begin
                tx_ready = 1'b0;
                stall--;
            end else if (rand_bits(2) == 0) begin
                tx_ready = 1'b0;
                stall    = rand_bits(2);
            end else begin
                tx_ready = 1'b1;
            end
            held      = tx_valid && !tx_ready;
            held_beat = tx_beat;
            if (tx_valid && tx_ready) begin
                if (!in_pkt) begin
                    cur_ch = next_channel();
                end
                if (cur_ch < 0) begin
                    flag_failure("transmit beat arrived with no packet expected");
                end else begin
                    check_tx_beat(cur_ch);
                end
                in_pkt = !tx_beat.last;
                got++;
            end
        end
        if (got < total) begin
            flag_failure($sformatf("timeout, %0d of %0d transmit beats seen", got, total));
        end
        tx_ready = 1'b1;
        for (int i = 0; i < HOLD_CYCLES; i++) begin
            @(negedge clk_pcie);
            if (tx_valid) begin
                flag_mismatch("extra transmit beat after all packets left");
            end
        end
    endtask

    task automatic tx_round();
        int ch;
        int len;
        int beats;
        int sent;
        clear_expected();
        tx_ready = 1'b0;
        sent     = 0;
        for (int p = 0; p < TX_PKTS; p++) begin
            ch    = rand_bits(2);
            len   = 1 + rand_bits(3) + rand_bits(2);
            beats = (len + 3) / 4;
            // stay within one queue depth per channel
            if (exp_wr[ch] + beats <= Q_DEPTH) begin
                for (int w = 0; w < len; w++) begin
                    pkt_words[w] = rand_bits(32);
                end
                model_pack(ch, len);
                send_host_packet(ch, len);
                sent += beats;
            end
        end
        for (int i = 0; i < HOLD_CYCLES; i++) begin
            @(negedge clk_pcie);
            if (tx_valid) begin
                flag_mismatch("o_tx_valid high while i_tx_ready held low");
            end
        end
        drain_tx(sent);
    endtask

    // ------------------------------------------------------------
    // sequence
    // ------------------------------------------------------------
    initial begin
        rst         = 1'b1;
        rx_beat     = '0;
        rx_valid    = 1'b0;
        cfg_filter  = 1'b0;
        all_filter  = 1'b0;
        host_word   = '0;
        host_valid  = 1'b0;
        tx_ready    = 1'b0;
        rx_exp      = '0;
        rx_exp_live = 1'b0;
        repeat (3) @(negedge clk_pcie);
        rst = 1'b0;

        // quiet after reset
        for (int i = 0; i < 10; i++) begin
            rx_cycle(rx_beat, 1'b0, 1'b0);
            if (tx_valid) begin
                flag_mismatch("o_tx_valid high after reset with no input");
            end
        end

        rx_burst(1'b0, 1'b0);
        rx_burst(1'b1, 1'b0);
        rx_burst(1'b0, 1'b1);
        rx_burst(1'b1, 1'b1);

        for (int r = 0; r < TX_ROUNDS; r++) begin
            tx_round();
        end

        $display("errors: %0d mismatches, %0d other", mismatch_count, other_errors);
        if ((mismatch_count == 0) && (other_errors == 0)) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+verif
hdl/tlp_pkg.sv
hdl/tlp_rx_filter.sv
hdl/tlp_tx_packer.sv
hdl/tlp_pkt_queue.sv
hdl/tlp_tx_arbiter.sv
hdl/tlp_ctrl_top.sv
verif/tb_tlp_ctrl.sv
